/* all.f */
+incdir+design
design/l2_reqs_pkg.sv
design/invack_counter.sv
design/l2_reqs.sv
design/l2_req_ctrl.sv
design/l2_reqs_top.sv
verif/l2_reqs_checker.sv
verif/l2_reqs_tb.sv

/* run.sh */
#!/bin/sh
# build and run with verilator; passes only if the pass line is printed
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f all.f --top-module l2_reqs_tb -o l2_reqs_sim
out=$(./obj_dir/l2_reqs_sim 2>&1 || true)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Regression passed"

/* verif/l2_reqs_tb.sv */
/* random event test of the miss buffer against a four-slot model. strobes go out only
   while busy_o is low; at most one write waits for acks, as the design requires */
`default_nettype none

`include "l2_reqs_macros.svh"

module l2_reqs_tb;

    import l2_reqs_pkg::*;

    localparam int N_RAND = 300;
    localparam int N_DIRECTED = 30;
    localparam int MAX_CYCLES = (N_RAND + N_DIRECTED) * 40;

    logic        clk, rst;
    logic        cpu_req_i, cpu_we_i, rsp_i, invack_i, fwd_i;
    addr_t       cpu_addr_i, rsp_addr_i, fwd_addr_i, done_addr_o;
    word_t       cpu_wdata_i, done_data_o;
    line_t       rsp_line_i;
    invack_cnt_t rsp_invack_i;
    fwd_msg_t    fwd_msg_i;
    logic        busy_o, req_accept_o, req_reject_o, done_o, fwd_hit_o, fwd_stall_o;

    // model of the slots and of the forward outputs
    req_state_t  m_state [`N_REQS];
    addr_t       m_addr  [`N_REQS];
    logic        m_we    [`N_REQS];
    word_t       m_wdata [`N_REQS];
    int          m_ima;
    invack_cnt_t m_acks;
    logic        m_hit, m_stall;
    addr_t       m_stall_addr;

    // what the current event should produce
    int    e_cyc;
    logic  e_acc, e_rej, e_done, e_fwd, e_hit, e_stall;
    addr_t e_daddr;
    word_t e_ddata;

    integer seed;
    string  test_name;
    int     err_count = 0;
    int     cycles = 0;

    l2_reqs_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: the run did not end within %0d cycles", MAX_CYCLES);
            $display("Regression failed");
            $fatal(1, "run stopped by cycle limit");
        end
    end

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            err_count++;
            $display("MISMATCH %s %s: expected %0h, actual %0h", test_name, what,
                     expected, actual);
            $display("Regression failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic addr_t mk_addr(input int tag, input int set, input int woff);
        return {tag_t'(tag), set_t'(set), woff_t'(woff)};
    endfunction

    // narrow set range so conflicts and a full buffer both happen
    function automatic addr_t rand_addr();
        return mk_addr(rand_below(4), rand_below(5), rand_below(4));
    endfunction

    function automatic line_t rand_line();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    function automatic logic same_line(input addr_t a, input addr_t b);
        return a[`ADDR_BITS-1:`WOFF_BITS] == b[`ADDR_BITS-1:`WOFF_BITS];
    endfunction

    function automatic int find_slot(input addr_t addr);
        int s;
        s = -1;
        for (int i = 0; i < `N_REQS; i++) begin
            if (m_state[i] != INVALID && same_line(m_addr[i], addr)) begin
                s = i;
            end
        end
        return s;
    endfunction

    task automatic clear_expect();
        e_cyc = 0;
        e_acc = 1'b0;
        e_rej = 1'b0;
        e_done = 1'b0;
        e_fwd = 1'b0;
        e_hit = 1'b0;
        e_stall = 1'b0;
        e_daddr = '0;
        e_ddata = '0;
    endtask

    task automatic expect_done(input int s, input word_t data);
        e_done = 1'b1;
        e_daddr = m_addr[s];
        e_ddata = data;
        m_state[s] = INVALID;
    endtask

    // checks every cycle of one event until the sequencer is idle again
    task automatic finish_event();
        int   c;
        logic at_end;
        c = 0;
        do begin
            @(negedge clk);
            c++;
            at_end = (c == e_cyc);
            if (c == 1) begin
                cpu_req_i = 1'b0;
                rsp_i = 1'b0;
                invack_i = 1'b0;
                fwd_i = 1'b0;
                if (e_fwd) begin
                    m_hit = e_hit;
                    m_stall = e_stall;
                end
            end
            check_value("req_accept_o", 32'(at_end && e_acc), 32'(req_accept_o));
            check_value("req_reject_o", 32'(at_end && e_rej), 32'(req_reject_o));
            check_value("done_o", 32'(at_end && e_done), 32'(done_o));
            check_value("fwd_hit_o", 32'(m_hit), 32'(fwd_hit_o));
            check_value("fwd_stall_o", 32'(m_stall), 32'(fwd_stall_o));
            if (at_end && e_done) begin
                check_value("done_addr_o", 32'(e_daddr), 32'(done_addr_o));
                check_value("done_data_o", e_ddata, done_data_o);
                // stall drops once the stalling line completes
                if (m_stall && same_line(e_daddr, m_stall_addr)) begin
                    m_stall = 1'b0;
                end
            end
        end while (busy_o);
        check_value("busy cycles", 32'(e_cyc + 1), 32'(c));
    endtask

    task automatic do_request(input addr_t addr, input logic we, input word_t wdata);
        int   free_slot;
        logic conflict;
        free_slot = -1;
        conflict = 1'b0;
        for (int i = 0; i < `N_REQS; i++) begin
            if (m_state[i] == INVALID) begin
                free_slot = i;
            end else if (m_addr[i][`WOFF_BITS +: `SET_BITS] == addr[`WOFF_BITS +: `SET_BITS]) begin
                conflict = 1'b1;
            end
        end
        clear_expect();
        cpu_req_i = 1'b1;
        cpu_addr_i = addr;
        cpu_we_i = we;
        cpu_wdata_i = wdata;
        e_cyc = 2;
        if (free_slot >= 0 && !conflict) begin
            e_acc = 1'b1;
            m_state[free_slot] = we ? IMAD : ISD;
            m_addr[free_slot] = addr;
            m_we[free_slot] = we;
            m_wdata[free_slot] = wdata;
        end else begin
            e_rej = 1'b1;
        end
        finish_event();
    endtask

    task automatic do_response(input addr_t addr, input line_t line, input invack_cnt_t n);
        int    s;
        word_t word;
        s = find_slot(addr);
        // a second write may not wait for acks
        if (m_state[s] == IMAD && m_ima >= 0) begin
            n = '0;
        end
        clear_expect();
        rsp_i = 1'b1;
        rsp_addr_i = addr;
        rsp_line_i = line;
        rsp_invack_i = n;
        e_cyc = 2;
        word = line[m_addr[s][`WOFF_BITS-1:0] * `WORD_BITS +: `WORD_BITS];
        if (m_state[s] == IMAD && n != '0) begin
            m_state[s] = IMA;
            m_ima = s;
            m_acks = n;
        end else begin
            expect_done(s, m_we[s] ? m_wdata[s] : word);
        end
        finish_event();
    endtask

    task automatic do_ack();
        clear_expect();
        invack_i = 1'b1;
        e_cyc = 1;
        m_acks = m_acks - invack_cnt_t'(1);
        if (m_acks == '0) begin
            expect_done(m_ima, m_wdata[m_ima]);
            m_ima = -1;
        end
        finish_event();
    endtask

    task automatic do_forward(input addr_t addr, input fwd_msg_t msg);
        int   s;
        logic stall;
        s = find_slot(addr);
        clear_expect();
        fwd_i = 1'b1;
        fwd_addr_i = addr;
        fwd_msg_i = msg;
        e_cyc = 1;
        e_fwd = 1'b1;
        e_hit = (s >= 0);
        stall = 1'b0;
        if (s >= 0) begin
            case (msg)
                FWD_PUTACK: stall = 1'b0;
                FWD_INV:    stall = (m_state[s] == ISD);
                default:    stall = 1'b1;
            endcase
        end
        e_stall = stall;
        if (stall) begin
            m_stall_addr = addr;
        end
        finish_event();
    endtask

    task automatic random_event();
        int    kind;
        int    pending[$];
        int    taken[$];
        addr_t addr;
        kind = rand_below(10);
        for (int i = 0; i < `N_REQS; i++) begin
            if (m_state[i] == ISD || m_state[i] == IMAD) begin
                pending.push_back(i);
            end
            if (m_state[i] != INVALID) begin
                taken.push_back(i);
            end
        end
        if (kind >= 4 && kind <= 6 && pending.size() > 0) begin
            addr = m_addr[pending[rand_below(pending.size())]];
            do_response(addr, rand_line(), invack_cnt_t'(rand_below(4)));
        end else if (kind == 7 && m_ima >= 0) begin
            do_ack();
        end else if (kind >= 7) begin
            if (rand_below(2) == 1 && taken.size() > 0) begin
                addr = m_addr[taken[rand_below(taken.size())]];
            end else begin
                addr = rand_addr();
            end
            do_forward(addr, fwd_msg_t'(2'(rand_below(4))));
        end else begin
            do_request(rand_addr(), rand_below(2) == 1, $random(seed));
        end
    endtask

    initial begin
        seed = 32'he146_cf15;
        rst = 1'b0;
        cpu_req_i = 1'b0;
        cpu_addr_i = '0;
        cpu_we_i = 1'b0;
        cpu_wdata_i = '0;
        rsp_i = 1'b0;
        rsp_addr_i = '0;
        rsp_line_i = '0;
        rsp_invack_i = '0;
        invack_i = 1'b0;
        fwd_i = 1'b0;
        fwd_addr_i = '0;
        fwd_msg_i = FWD_GETS;
        for (int i = 0; i < `N_REQS; i++) begin
            m_state[i] = INVALID;
        end
        m_ima = -1;
        m_acks = '0;
        m_hit = 1'b0;
        m_stall = 1'b0;
        m_stall_addr = '0;
        repeat (5) @(negedge clk);
        rst = 1'b1;

        test_name = "reset";
        check_value("outputs", 32'd0, 32'({busy_o, req_accept_o, req_reject_o, done_o,
                                            fwd_hit_o, fwd_stall_o}));
        do_forward(mk_addr(1, 1, 0), FWD_GETS);

        test_name = "read miss";
        do_request(mk_addr(5, 2, 3), 1'b0, 32'h0);
        do_response(mk_addr(5, 2, 3), rand_line(), 3'd2);

        test_name = "write miss acks";
        do_request(mk_addr(7, 3, 1), 1'b1, 32'h0bad_f00d);
        do_response(mk_addr(7, 3, 1), rand_line(), 3'd3);
        do_ack();
        do_ack();
        do_ack();
        test_name = "write miss no acks";
        do_request(mk_addr(7, 3, 2), 1'b1, 32'h1234_5678);
        do_response(mk_addr(7, 3, 2), rand_line(), 3'd0);

        test_name = "set conflict";
        do_request(mk_addr(1, 4, 0), 1'b0, 32'h0);
        do_request(mk_addr(2, 4, 0), 1'b0, 32'h0);
        test_name = "buffer full";
        do_request(mk_addr(1, 5, 0), 1'b0, 32'h0);
        do_request(mk_addr(1, 6, 0), 1'b0, 32'h0);
        do_request(mk_addr(1, 7, 0), 1'b0, 32'h0);
        do_request(mk_addr(1, 8, 0), 1'b0, 32'h0);

        test_name = "forward stall rules";
        do_forward(mk_addr(1, 4, 0), FWD_INV);
        do_forward(mk_addr(1, 4, 0), FWD_PUTACK);
        do_forward(mk_addr(1, 4, 0), FWD_GETS);
        do_response(mk_addr(1, 4, 0), rand_line(), 3'd0);
        do_request(mk_addr(3, 4, 1), 1'b1, 32'h00c0_ffee);
        do_forward(mk_addr(3, 4, 1), FWD_INV);
        do_forward(mk_addr(3, 4, 1), FWD_GETM);
        do_forward(mk_addr(9, 9, 0), FWD_GETM);

        test_name = "random mix";
        for (int n = 0; n < N_RAND; n++) begin
            random_event();
        end

        if (err_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/l2_reqs_checker.sv */
/* output assertions bound to l2_reqs_top; assumes a cpu strobe lasts one cycle
   and comes only while busy_o is low */
`default_nettype none

module l2_reqs_checker (
    input wire logic clk,
    input wire logic rst,
    input wire logic cpu_req_i,
    input wire logic busy_i,
    input wire logic accept_i,
    input wire logic reject_i,
    input wire logic done_i
);

    // decisions come alone and only two cycles after a strobe
    a_acc_rej_excl: assert property (@(posedge clk) disable iff (!rst)
        (accept_i || reject_i) |-> !(accept_i && reject_i) && $past(cpu_req_i && !busy_i, 2))
        else $error("accept or reject without a cpu request, or both high together");

    // decision comes two cycles after the strobe
    a_req_answered: assert property (@(posedge clk) disable iff (!rst)
        cpu_req_i && !busy_i |-> ##2 (accept_i != reject_i))
        else $error("cpu request not answered by exactly one of accept or reject");

    a_no_done_in_reset: assert property (@(posedge clk) !rst |-> !done_i)
        else $error("done pulse while reset is active");

endmodule

bind l2_reqs_top l2_reqs_checker u_checker (
    .clk, .rst, .cpu_req_i, .busy_i(busy_o), .accept_i(req_accept_o),
    .reject_i(req_reject_o), .done_i(done_o)
);

`default_nettype wire

/* design/l2_reqs_top.sv */
/* strobes are accepted only while busy_o is low, one per cycle;
   responses and acks must match a pending slot */
`default_nettype none

module l2_reqs_top (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                cpu_req_i,
    input  l2_reqs_pkg::addr_t       cpu_addr_i,
    input  wire logic                cpu_we_i,
    input  l2_reqs_pkg::word_t       cpu_wdata_i,
    input  wire logic                rsp_i,
    input  l2_reqs_pkg::addr_t       rsp_addr_i,
    input  l2_reqs_pkg::line_t       rsp_line_i,
    input  l2_reqs_pkg::invack_cnt_t rsp_invack_i,
    input  wire logic                invack_i,
    input  wire logic                fwd_i,
    input  l2_reqs_pkg::addr_t       fwd_addr_i,
    input  l2_reqs_pkg::fwd_msg_t    fwd_msg_i,
    output logic                     busy_o,
    output logic                     req_accept_o,
    output logic                     req_reject_o,
    output logic                     done_o,
    output l2_reqs_pkg::addr_t       done_addr_o,
    output l2_reqs_pkg::word_t       done_data_o,
    output logic                     fwd_hit_o,
    output logic                     fwd_stall_o
);

    import l2_reqs_pkg::*;

    logic [1:0]  reqs_op_code;
    logic        fill_reqs, wr_req_state, wr_req_line, we, reqs_hit;
    logic        set_conflict, set_fwd_stall, clr_fwd_stall, sel_we;
    logic        cnt_load, cnt_dec, cnt_zero;
    addr_t       op_addr;
    word_t       wdata, sel_wdata;
    req_state_t  state_wr_data, sel_state;
    line_t       line_wr_data, sel_line;
    fwd_msg_t    fwd_msg;
    reqs_idx_t   reqs_i;
    woff_t       sel_woff;
    invack_cnt_t cnt_val;

    l2_req_ctrl u_ctrl (
        .clk, .rst, .cpu_req_i, .cpu_addr_i, .cpu_we_i, .cpu_wdata_i,
        .rsp_i, .rsp_addr_i, .rsp_line_i, .rsp_invack_i, .invack_i,
        .fwd_i, .fwd_addr_i, .fwd_msg_i,
        .reqs_op_code_o(reqs_op_code), .fill_reqs_o(fill_reqs),
        .wr_req_state_o(wr_req_state), .wr_req_line_o(wr_req_line),
        .op_addr_o(op_addr), .we_o(we), .wdata_o(wdata),
        .state_wr_data_o(state_wr_data), .line_wr_data_o(line_wr_data),
        .fwd_msg_o(fwd_msg), .reqs_i_i(reqs_i), .reqs_hit_i(reqs_hit),
        .set_conflict_i(set_conflict), .set_fwd_stall_i(set_fwd_stall),
        .clr_fwd_stall_i(clr_fwd_stall), .sel_state_i(sel_state),
        .sel_woff_i(sel_woff), .sel_we_i(sel_we), .sel_wdata_i(sel_wdata),
        .sel_line_i(sel_line), .cnt_load_o(cnt_load), .cnt_val_o(cnt_val),
        .cnt_dec_o(cnt_dec), .cnt_zero_i(cnt_zero),
        .busy_o, .req_accept_o, .req_reject_o, .done_o, .done_addr_o,
        .done_data_o, .fwd_hit_o, .fwd_stall_o
    );

    l2_reqs u_reqs (
        .clk, .rst, .reqs_op_code_i(reqs_op_code), .fill_reqs_i(fill_reqs),
        .wr_req_state_i(wr_req_state), .wr_req_line_i(wr_req_line),
        .op_addr_i(op_addr), .we_i(we), .wdata_i(wdata),
        .state_wr_data_i(state_wr_data), .line_wr_data_i(line_wr_data),
        .fwd_msg_i(fwd_msg), .reqs_i_o(reqs_i), .reqs_hit_o(reqs_hit),
        .set_conflict_o(set_conflict), .set_fwd_stall_o(set_fwd_stall),
        .clr_fwd_stall_o(clr_fwd_stall), .sel_state_o(sel_state),
        .sel_woff_o(sel_woff), .sel_we_o(sel_we), .sel_wdata_o(sel_wdata),
        .sel_line_o(sel_line)
    );

    invack_counter u_cnt (
        .clk, .rst, .load_i(cnt_load), .load_val_i(cnt_val),
        .dec_i(cnt_dec), .cnt_zero_o(cnt_zero)
    );

endmodule

`default_nettype wire

/* design/l2_req_ctrl.sv */
/* one event at a time; requests and responses decide two cycles after the strobe,
   acks and forwards one cycle after. only one slot may wait in IMA */
`default_nettype none

`include "l2_reqs_macros.svh"

module l2_req_ctrl (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                cpu_req_i,
    input  l2_reqs_pkg::addr_t       cpu_addr_i,
    input  wire logic                cpu_we_i,
    input  l2_reqs_pkg::word_t       cpu_wdata_i,
    input  wire logic                rsp_i,
    input  l2_reqs_pkg::addr_t       rsp_addr_i,
    input  l2_reqs_pkg::line_t       rsp_line_i,
    input  l2_reqs_pkg::invack_cnt_t rsp_invack_i,
    input  wire logic                invack_i,
    input  wire logic                fwd_i,
    input  l2_reqs_pkg::addr_t       fwd_addr_i,
    input  l2_reqs_pkg::fwd_msg_t    fwd_msg_i,
    output logic [1:0]               reqs_op_code_o,
    output logic                     fill_reqs_o,
    output logic                     wr_req_state_o,
    output logic                     wr_req_line_o,
    output l2_reqs_pkg::addr_t       op_addr_o,
    output logic                     we_o,
    output l2_reqs_pkg::word_t       wdata_o,
    output l2_reqs_pkg::req_state_t  state_wr_data_o,
    output l2_reqs_pkg::line_t       line_wr_data_o,
    output l2_reqs_pkg::fwd_msg_t    fwd_msg_o,
    input  l2_reqs_pkg::reqs_idx_t   reqs_i_i,
    input  wire logic                reqs_hit_i,
    input  wire logic                set_conflict_i,
    input  wire logic                set_fwd_stall_i,
    input  wire logic                clr_fwd_stall_i,
    input  l2_reqs_pkg::req_state_t  sel_state_i,
    input  l2_reqs_pkg::woff_t       sel_woff_i,
    input  wire logic                sel_we_i,
    input  l2_reqs_pkg::word_t       sel_wdata_i,
    input  l2_reqs_pkg::line_t       sel_line_i,
    output logic                     cnt_load_o,
    output l2_reqs_pkg::invack_cnt_t cnt_val_o,
    output logic                     cnt_dec_o,
    input  wire logic                cnt_zero_i,
    output logic                     busy_o,
    output logic                     req_accept_o,
    output logic                     req_reject_o,
    output logic                     done_o,
    output l2_reqs_pkg::addr_t       done_addr_o,
    output l2_reqs_pkg::word_t       done_data_o,
    output logic                     fwd_hit_o,
    output logic                     fwd_stall_o
);

    import l2_reqs_pkg::*;

    localparam logic [1:0] EV_REQ = 2'd0;
    localparam logic [1:0] EV_RSP = 2'd1;
    localparam logic [1:0] EV_ACK = 2'd2;
    localparam logic [1:0] EV_FWD = 2'd3;

    ctrl_state_t state_q, state_d;
    logic [1:0]  ev_q;
    logic        conflict_q, ima_valid_q, fwd_hit_q, fwd_stall_q;
    reqs_idx_t   ima_idx_q, stall_idx_q;
    addr_t       addr_q, ima_addr_q;
    logic        we_q;
    word_t       wdata_q;
    line_t       line_q;
    invack_cnt_t inv_q;

    logic  ack_go, decide_req, decide_rsp, decide_ack, decide_fwd;
    logic  rsp_hit, ima_set, ack_done;
    word_t line_word;

    assign ack_go     = invack_i && ima_valid_q;
    assign decide_req = (state_q == DECIDE) && (ev_q == EV_REQ);
    assign decide_rsp = (state_q == DECIDE) && (ev_q == EV_RSP);
    assign decide_ack = (state_q == DECIDE) && (ev_q == EV_ACK);
    assign decide_fwd = (state_q == DECIDE) && (ev_q == EV_FWD);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (cpu_req_i || rsp_i) begin
                    state_d = PEEK;
                end else if (ack_go || fwd_i) begin
                    // lookup already issued in the strobe cycle
                    state_d = DECIDE;
                end
            end
            PEEK:    state_d = DECIDE;
            default: state_d = IDLE;
        endcase
    end

    always_comb begin
        reqs_op_code_o = `REQS_IDLE;
        if (state_q == IDLE) begin
            if (fwd_i) begin
                reqs_op_code_o = `REQS_PEEK_FWD;
            end else if (ack_go) begin
                reqs_op_code_o = `REQS_LOOKUP;
            end
        end else if (state_q == PEEK) begin
            reqs_op_code_o = (ev_q == EV_REQ) ? `REQS_PEEK_REQ : `REQS_LOOKUP;
        end
    end

    assign op_addr_o = (state_q != IDLE) ? addr_q : (fwd_i ? fwd_addr_i : ima_addr_q);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q     <= IDLE;
            ev_q        <= EV_REQ;
            conflict_q  <= 1'b0;
            ima_valid_q <= 1'b0;
            fwd_hit_q   <= 1'b0;
            fwd_stall_q <= 1'b0;
            stall_idx_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == IDLE) begin
                if (cpu_req_i) begin
                    ev_q <= EV_REQ;
                end else if (rsp_i) begin
                    ev_q <= EV_RSP;
                end else if (ack_go) begin
                    ev_q <= EV_ACK;
                end else if (fwd_i) begin
                    ev_q <= EV_FWD;
                end
            end
            if (state_q == PEEK) begin
                conflict_q <= set_conflict_i;
            end
            if (ima_set) begin
                ima_valid_q <= 1'b1;
            end else if (ack_done) begin
                ima_valid_q <= 1'b0;
            end
            if (decide_fwd) begin
                fwd_hit_q   <= reqs_hit_i;
                stall_idx_q <= reqs_i_i;
            end
            if (state_q == IDLE && fwd_i) begin
                if (set_fwd_stall_i) begin
                    fwd_stall_q <= 1'b1;
                end else if (clr_fwd_stall_i) begin
                    fwd_stall_q <= 1'b0;
                end
            end else if (done_o && reqs_i_i == stall_idx_q) begin
                // the stalling slot has completed
                fwd_stall_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == IDLE) begin
            if (cpu_req_i) begin
                addr_q  <= cpu_addr_i;
                we_q    <= cpu_we_i;
                wdata_q <= cpu_wdata_i;
            end else if (rsp_i) begin
                addr_q <= rsp_addr_i;
                line_q <= rsp_line_i;
                inv_q  <= rsp_invack_i;
            end else if (ack_go) begin
                addr_q <= ima_addr_q;
            end
        end
        if (ima_set) begin
            ima_addr_q <= addr_q;
            ima_idx_q  <= reqs_i_i;
        end
    end

    assign rsp_hit  = decide_rsp && reqs_hit_i;
    assign ima_set  = rsp_hit && sel_state_i == IMAD && inv_q != '0;
    assign ack_done = decide_ack && cnt_zero_i && reqs_hit_i && reqs_i_i == ima_idx_q;

    assign req_accept_o = decide_req && reqs_hit_i && !conflict_q;
    assign req_reject_o = decide_req && !(reqs_hit_i && !conflict_q);
    assign fill_reqs_o  = req_accept_o;

    assign wr_req_state_o  = rsp_hit || ack_done;
    assign wr_req_line_o   = rsp_hit;
    assign state_wr_data_o = decide_req ? (we_q ? IMAD : ISD) : (ima_set ? IMA : INVALID);
    assign line_wr_data_o  = line_q;
    assign we_o            = we_q;
    assign wdata_o         = wdata_q;
    assign fwd_msg_o       = fwd_msg_i;

    assign cnt_load_o = ima_set;
    assign cnt_val_o  = inv_q;
    assign cnt_dec_o  = (state_q == IDLE) && ack_go;

    assign line_word   = sel_line_i[sel_woff_i*`WORD_BITS +: `WORD_BITS];
    assign done_o      = (rsp_hit && !ima_set) || ack_done;
    assign done_addr_o = {addr_q[`ADDR_BITS-1:`WOFF_BITS], sel_woff_i};
    assign done_data_o = sel_we_i ? sel_wdata_i : line_word;

    assign busy_o      = (state_q != IDLE);
    assign fwd_hit_o   = decide_fwd ? reqs_hit_i : fwd_hit_q;
    assign fwd_stall_o = fwd_stall_q;

endmodule

`default_nettype wire

/* design/l2_reqs.sv */
/* four-slot miss buffer. all writes go to the slot at the registered index,
   lookups are combinational and assume at most one valid slot per line */
`default_nettype none

`include "l2_reqs_macros.svh"

module l2_reqs (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic [1:0]             reqs_op_code_i,
    input  wire logic                   fill_reqs_i,
    input  wire logic                   wr_req_state_i,
    input  wire logic                   wr_req_line_i,
    input  l2_reqs_pkg::addr_t          op_addr_i,
    input  wire logic                   we_i,
    input  l2_reqs_pkg::word_t          wdata_i,
    input  l2_reqs_pkg::req_state_t     state_wr_data_i,
    input  l2_reqs_pkg::line_t          line_wr_data_i,
    input  l2_reqs_pkg::fwd_msg_t       fwd_msg_i,
    output l2_reqs_pkg::reqs_idx_t      reqs_i_o,
    output logic                        reqs_hit_o,
    output logic                        set_conflict_o,
    output logic                        set_fwd_stall_o,
    output logic                        clr_fwd_stall_o,
    output l2_reqs_pkg::req_state_t     sel_state_o,
    output l2_reqs_pkg::woff_t          sel_woff_o,
    output logic                        sel_we_o,
    output l2_reqs_pkg::word_t          sel_wdata_o,
    output l2_reqs_pkg::line_t          sel_line_o
);

    import l2_reqs_pkg::*;

    req_state_t state_q [`N_REQS];
    tag_t       tag_q   [`N_REQS];
    set_t       set_q   [`N_REQS];
    woff_t      woff_q  [`N_REQS];
    logic       we_q    [`N_REQS];
    word_t      wdata_q [`N_REQS];
    line_t      line_q  [`N_REQS];

    tag_t      op_tag;
    set_t      op_set;
    woff_t     op_woff;
    reqs_idx_t idx_next;
    logic      hit_next;
    logic      fwd_stall;

    assign op_tag  = op_addr_i[`ADDR_BITS-1 -: `TAG_BITS];
    assign op_set  = op_addr_i[`WOFF_BITS +: `SET_BITS];
    assign op_woff = op_addr_i[`WOFF_BITS-1:0];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < `N_REQS; i++) begin
                state_q[i] <= INVALID;
            end
        end else if (fill_reqs_i || wr_req_state_i) begin
            state_q[reqs_i_o] <= state_wr_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_reqs_i) begin
            tag_q[reqs_i_o]   <= op_tag;
            set_q[reqs_i_o]   <= op_set;
            woff_q[reqs_i_o]  <= op_woff;
            we_q[reqs_i_o]    <= we_i;
            wdata_q[reqs_i_o] <= wdata_i;
        end
        if (fill_reqs_i || wr_req_line_i) begin
            line_q[reqs_i_o] <= line_wr_data_i;
        end
    end

    // on PEEK_REQ the hit flag means a free slot was found
    always_comb begin
        idx_next        = '0;
        hit_next        = 1'b0;
        fwd_stall       = 1'b0;
        set_conflict_o  = 1'b0;
        set_fwd_stall_o = 1'b0;
        clr_fwd_stall_o = 1'b0;
        case (reqs_op_code_i)
            `REQS_PEEK_REQ: begin
                for (int i = 0; i < `N_REQS; i++) begin
                    if (state_q[i] == INVALID) begin
                        idx_next = reqs_idx_t'(i);
                        hit_next = 1'b1;
                    end else if (set_q[i] == op_set) begin
                        set_conflict_o = 1'b1;
                    end
                end
            end
            `REQS_LOOKUP: begin
                for (int i = 0; i < `N_REQS; i++) begin
                    if (state_q[i] != INVALID && tag_q[i] == op_tag && set_q[i] == op_set) begin
                        idx_next = reqs_idx_t'(i);
                        hit_next = 1'b1;
                    end
                end
            end
            `REQS_PEEK_FWD: begin
                for (int i = 0; i < `N_REQS; i++) begin
                    if (state_q[i] != INVALID && tag_q[i] == op_tag && set_q[i] == op_set) begin
                        idx_next = reqs_idx_t'(i);
                        hit_next = 1'b1;
                        case (fwd_msg_i)
                            FWD_PUTACK: fwd_stall = 1'b0;
                            FWD_INV:    fwd_stall = (state_q[i] == ISD);
                            default:    fwd_stall = 1'b1;
                        endcase
                    end
                end
                // a miss clears a stale stall too
                set_fwd_stall_o = fwd_stall;
                clr_fwd_stall_o = !fwd_stall;
            end
            default: begin
                hit_next = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            reqs_i_o   <= '0;
            reqs_hit_o <= 1'b0;
        end else if (reqs_op_code_i != `REQS_IDLE) begin
            reqs_i_o   <= idx_next;
            reqs_hit_o <= hit_next;
        end
    end

    assign sel_state_o = state_q[reqs_i_o];
    assign sel_woff_o  = woff_q[reqs_i_o];
    assign sel_we_o    = we_q[reqs_i_o];
    assign sel_wdata_o = wdata_q[reqs_i_o];
    // bypass so a line being written is readable in the same cycle
    assign sel_line_o  = wr_req_line_i ? line_wr_data_i : line_q[reqs_i_o];

endmodule

`default_nettype wire

/* design/invack_counter.sv */
/* pending invalidation ack count of the single IMA slot.
   load wins over decrement; the count never wraps below zero */
`default_nettype none

module invack_counter (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                load_i,
    input  l2_reqs_pkg::invack_cnt_t load_val_i,
    input  wire logic                dec_i,
    output logic                     cnt_zero_o
);

    import l2_reqs_pkg::*;

    invack_cnt_t cnt_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cnt_q <= '0;
        end else if (load_i) begin
            cnt_q <= load_val_i;
        end else if (dec_i && cnt_q != '0) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    assign cnt_zero_o = (cnt_q == '0);

endmodule

`default_nettype wire

/* design/l2_reqs_pkg.sv */
/* types shared by the request buffer, its sequencer and the ack counter.
   widths come from the macro header */
`default_nettype none

`include "l2_reqs_macros.svh"

package l2_reqs_pkg;

    typedef logic [`ADDR_BITS-1:0] addr_t;
    typedef logic [`TAG_BITS-1:0] tag_t;
    typedef logic [`SET_BITS-1:0] set_t;
    typedef logic [`WOFF_BITS-1:0] woff_t;
    typedef logic [`WORD_BITS-1:0] word_t;
    typedef logic [`WORD_BITS*`WORDS_PER_LINE-1:0] line_t;
    typedef logic [`REQS_BITS-1:0] reqs_idx_t;
    typedef logic [`INVACK_BITS-1:0] invack_cnt_t;

    // slot states, no eviction states
    typedef enum logic [1:0] {
        INVALID = 2'd0,
        ISD     = 2'd1,
        IMAD    = 2'd2,
        IMA     = 2'd3
    } req_state_t;

    typedef enum logic [1:0] {
        FWD_GETS   = 2'd0,
        FWD_GETM   = 2'd1,
        FWD_INV    = 2'd2,
        FWD_PUTACK = 2'd3
    } fwd_msg_t;

    // sequencer
    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        PEEK   = 2'd1,
        DECIDE = 2'd2
    } ctrl_state_t;

endpackage

`default_nettype wire

/* design/l2_reqs_macros.svh */
/* sizes and operation codes of the request buffer. the address is tag, set, word offset;
   changing a width here changes the package types as well */
`ifndef L2_REQS_MACROS_SVH
`define L2_REQS_MACROS_SVH

// buffer size
`define N_REQS 4
`define REQS_BITS 2

// address fields, msb first
`define TAG_BITS 8
`define SET_BITS 4
`define WOFF_BITS 2
`define ADDR_BITS 14

`define WORD_BITS 32
`define WORDS_PER_LINE 4

// widest pending invalidation ack count
`define INVACK_BITS 3

// buffer operation codes
`define REQS_IDLE 2'b00
`define REQS_LOOKUP 2'b01
`define REQS_PEEK_REQ 2'b10
`define REQS_PEEK_FWD 2'b11

`endif
